// File: src/mem_pkg.sv
package mem_pkg;

    // data path and id widths
    localparam int XLEN      = 32;
    localparam int INST_ID_W = 64;

    // data memory geometry
    localparam int RAM_WORDS      = 256;
    localparam int RAM_ADDR_W     = 8;
    localparam int RAM_RD_LATENCY = 2;

    typedef logic [XLEN-1:0]      xlen_t;
    typedef logic [INST_ID_W-1:0] inst_id_t;
    typedef logic [3:0]           wmask_t;

    // memory operation codes carried down from execute
    typedef enum logic [3:0] {
        MEM_NONE    = 4'd0,
        MEM_LB      = 4'd1,
        MEM_LBU     = 4'd2,
        MEM_LH      = 4'd3,
        MEM_LHU     = 4'd4,
        MEM_LW      = 4'd5,
        MEM_SB      = 4'd6,
        MEM_SH      = 4'd7,
        MEM_SW      = 4'd8,
        MEM_AMOSWAP = 4'd9
    } mem_op_t;

    // memory-access stage FSM
    typedef enum logic [1:0] {
        ST_IDLE       = 2'd0,
        ST_REQ        = 2'd1,
        ST_WAIT_RDATA = 2'd2
    } stage_state_t;

    // held after reset, never issued by the front end
    localparam inst_id_t INST_ID_NONE = 64'hffff_0000_0000_0000;

endpackage

// File: src/dmem_if.sv
`timescale 1ns/1ps

interface dmem_if;
    import mem_pkg::*;

    // request, held until ready
    logic   req;
    logic   wen;
    xlen_t  addr;
    xlen_t  wdata;
    wmask_t wmask;

    // response side
    logic   ready;
    logic   rvalid;
    xlen_t  rdata;

    modport requester (
        output req, wen, addr, wdata, wmask,
        input  ready, rvalid, rdata
    );

    modport responder (
        input  req, wen, addr, wdata, wmask,
        output ready, rvalid, rdata
    );

endinterface

// File: src/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic              clk,
    input  logic              rst_n,

    input  logic              mem_valid,
    input  mem_pkg::inst_id_t mem_inst_id,
    input  mem_pkg::mem_op_t  mem_op,
    input  mem_pkg::xlen_t    mem_addr,
    input  mem_pkg::xlen_t    mem_wdata,
    input  logic              pipeline_flush,

    output logic              mem_stall,
    output logic              wb_valid,
    output mem_pkg::inst_id_t wb_inst_id,
    output mem_pkg::xlen_t    wb_rdata,

    dmem_if.requester         dmem
);
    import mem_pkg::*;

    stage_state_t state;
    inst_id_t     saved_id;
    logic         done;
    logic         swap_wr;
    xlen_t        rdata_q;

    mem_op_t      eff_op;
    logic         is_mem;
    logic         is_store;
    logic         may_start;
    logic         abort;

    // sign or zero extension by the original op
    function automatic xlen_t extend_load(mem_op_t op, xlen_t raw);
        case (op)
            MEM_LB:  return {{24{raw[7]}}, raw[7:0]};
            MEM_LBU: return {24'b0, raw[7:0]};
            MEM_LH:  return {{16{raw[15]}}, raw[15:0]};
            MEM_LHU: return {16'b0, raw[15:0]};
            default: return raw;
        endcase
    endfunction

    // second half of a swap is issued as a plain word store
    assign eff_op   = swap_wr ? MEM_SW : mem_op;
    assign is_mem   = mem_op != MEM_NONE;
    assign is_store = eff_op == MEM_SB || eff_op == MEM_SH || eff_op == MEM_SW;

    // an instruction still held after finishing must not run again
    assign may_start = !(done && saved_id == mem_inst_id);
    assign abort     = pipeline_flush || !mem_valid || !is_mem;

    assign mem_stall = mem_valid && (state != ST_IDLE || (is_mem && may_start));

    assign dmem.req   = state == ST_REQ;
    assign dmem.wen   = is_store;
    assign dmem.addr  = mem_addr;
    assign dmem.wdata = mem_wdata;

    always_comb begin
        case (eff_op)
            MEM_SB:  dmem.wmask = 4'b0001;
            MEM_SH:  dmem.wmask = 4'b0011;
            default: dmem.wmask = 4'b1111;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            saved_id <= INST_ID_NONE;
            done     <= 1'b0;
            swap_wr  <= 1'b0;
        end else begin
            if (mem_valid) begin
                saved_id <= mem_inst_id;
            end
            if (abort) begin
                state   <= ST_IDLE;
                done    <= 1'b0;
                swap_wr <= 1'b0;
            end else begin
                case (state)
                    ST_IDLE: begin
                        if (may_start) begin
                            state <= ST_REQ;
                            done  <= 1'b0;
                        end
                    end
                    ST_REQ: begin
                        if (dmem.ready) begin
                            if (is_store) begin
                                state   <= ST_IDLE;
                                done    <= 1'b1;
                                swap_wr <= 1'b0;
                            end else begin
                                state <= ST_WAIT_RDATA;
                            end
                        end
                    end
                    ST_WAIT_RDATA: begin
                        if (dmem.rvalid) begin
                            if (mem_op == MEM_AMOSWAP) begin
                                // old word kept, now write the new one
                                state   <= ST_REQ;
                                swap_wr <= 1'b1;
                            end else begin
                                state <= ST_IDLE;
                                done  <= 1'b1;
                            end
                        end
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    // read data latched on the valid pulse
    always_ff @(posedge clk) begin
        if (state == ST_WAIT_RDATA && dmem.rvalid) begin
            rdata_q <= dmem.rdata;
        end
    end

    assign wb_valid   = mem_valid && !pipeline_flush;
    assign wb_inst_id = mem_inst_id;
    assign wb_rdata   = extend_load(mem_op, rdata_q);

    // request and its fields held until the memory takes it
    a_req_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (dmem.req && !dmem.ready && !abort) |=>
            (dmem.req && $stable(dmem.wen) && $stable(dmem.addr)
             && $stable(dmem.wdata) && $stable(dmem.wmask))
    );

    // memory only answers a read this stage is waiting for
    a_rvalid_expected: assert property (
        @(posedge clk) disable iff (!rst_n)
        dmem.rvalid |-> state == ST_WAIT_RDATA
    );

endmodule

// File: src/data_ram.sv
`timescale 1ns/1ps

module data_ram (
    input  logic      clk,
    input  logic      rst_n,
    dmem_if.responder dmem
);
    import mem_pkg::*;

    xlen_t                     mem [RAM_WORDS];
    logic [RAM_ADDR_W-1:0]     word_addr;
    logic                      rd_accept;
    logic                      wr_accept;
    logic                      ready_q;
    logic                      rd_pending;

    // read return shift, one slot per cycle of latency
    logic [RAM_RD_LATENCY-1:0] vld_pipe;
    xlen_t                     data_pipe [RAM_RD_LATENCY];

    assign word_addr  = dmem.addr[RAM_ADDR_W-1:0];
    assign rd_accept  = dmem.req && ready_q && !dmem.wen;
    assign wr_accept  = dmem.req && ready_q && dmem.wen;
    assign rd_pending = |vld_pipe;

    // byte-lane write at the acceptance edge
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (dmem.wmask[lane]) begin
                    mem[word_addr][lane*8 +: 8] <= dmem.wdata[lane*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            data_pipe[0] <= mem[word_addr];
        end
        for (int i = 1; i < RAM_RD_LATENCY; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe[0] <= rd_accept;
            for (int i = 1; i < RAM_RD_LATENCY; i++) begin
                vld_pipe[i] <= vld_pipe[i-1];
            end
        end
    end

    // busy from read acceptance through the rvalid cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready_q <= 1'b1;
        end else if (rd_accept) begin
            ready_q <= 1'b0;
        end else if (dmem.rvalid) begin
            ready_q <= 1'b1;
        end
    end

    assign dmem.ready  = ready_q;
    assign dmem.rvalid = vld_pipe[RAM_RD_LATENCY-1];
    assign dmem.rdata  = data_pipe[RAM_RD_LATENCY-1];

    // ready must never let a request in on top of a read in flight
    a_no_accept_pending: assert property (
        @(posedge clk) disable iff (!rst_n)
        (dmem.req && dmem.ready) |-> !rd_pending
    );

endmodule

// File: src/mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top (
    input  logic              clk,
    input  logic              rst_n,

    // from execute
    input  logic              mem_valid,
    input  mem_pkg::inst_id_t mem_inst_id,
    input  mem_pkg::mem_op_t  mem_op,
    input  mem_pkg::xlen_t    mem_addr,
    input  mem_pkg::xlen_t    mem_wdata,
    input  logic              pipeline_flush,

    // to execute and writeback
    output logic              mem_stall,
    output logic              wb_valid,
    output mem_pkg::inst_id_t wb_inst_id,
    output mem_pkg::xlen_t    wb_rdata
);

    dmem_if dmem_bus ();

    mem_stage u_mem_stage (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_valid      (mem_valid),
        .mem_inst_id    (mem_inst_id),
        .mem_op         (mem_op),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .pipeline_flush (pipeline_flush),
        .mem_stall      (mem_stall),
        .wb_valid       (wb_valid),
        .wb_inst_id     (wb_inst_id),
        .wb_rdata       (wb_rdata),
        .dmem           (dmem_bus.requester)
    );

    // stands in for cache and bus
    data_ram u_data_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .dmem  (dmem_bus.responder)
    );

endmodule

// File: verif/tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys;
    import mem_pkg::*;

    localparam int RNG_SEED       = 62;
    localparam int RESET_CYCLES   = 8;
    // preload plus directed tests plus random mix come to about 950 instructions
    localparam int MAX_INSTRS     = 1000;
    // a swap, the longest operation, needs six
    localparam int CYCLES_PER_OP  = 8;
    localparam int TIMEOUT_CYCLES = MAX_INSTRS * CYCLES_PER_OP + 4 * RESET_CYCLES;

    logic     clk;
    logic     rst_n;
    logic     mem_valid;
    inst_id_t mem_inst_id;
    mem_op_t  mem_op;
    xlen_t    mem_addr;
    xlen_t    mem_wdata;
    logic     pipeline_flush;
    logic     mem_stall;
    logic     wb_valid;
    inst_id_t wb_inst_id;
    xlen_t    wb_rdata;

    xlen_t    model_mem [RAM_WORDS];
    inst_id_t next_id;
    int       cycle_count;
    int       test_errors;
    int       tests_passed;
    int       tests_failed;

    mem_subsys_top u_mem_subsys_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_valid      (mem_valid),
        .mem_inst_id    (mem_inst_id),
        .mem_op         (mem_op),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .pipeline_flush (pipeline_flush),
        .mem_stall      (mem_stall),
        .wb_valid       (wb_valid),
        .wb_inst_id     (wb_inst_id),
        .wb_rdata       (wb_rdata)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    // sub-word stores land in the low lanes
    function automatic xlen_t store_merge(mem_op_t op, xlen_t old_word, xlen_t data);
        case (op)
            MEM_SB:  return {old_word[31:8], data[7:0]};
            MEM_SH:  return {old_word[31:16], data[15:0]};
            default: return data;
        endcase
    endfunction

    function automatic xlen_t load_expect(mem_op_t op, xlen_t word);
        xlen_t b;
        xlen_t h;
        b = xlen_t'(word[7:0]);
        h = xlen_t'(word[15:0]);
        case (op)
            MEM_LB:  return word[7] ? (b | 32'hffff_ff00) : b;
            MEM_LBU: return b;
            MEM_LH:  return word[15] ? (h | 32'hffff_0000) : h;
            MEM_LHU: return h;
            default: return word;
        endcase
    endfunction

    // present one instruction and hold it until mem_stall drops
    task automatic issue(input mem_op_t op, input xlen_t addr, input xlen_t wdata,
                         input logic flush, output xlen_t rdata, output int stall_cycles);
        inst_id_t id;
        id             = next_id;
        next_id        = next_id + 1;
        mem_valid      = 1'b1;
        mem_inst_id    = id;
        mem_op         = op;
        mem_addr       = addr;
        mem_wdata      = wdata;
        pipeline_flush = flush;
        stall_cycles   = 0;
        @(negedge clk);
        while (mem_stall) begin
            stall_cycles++;
            @(negedge clk);
        end
        check("wb_inst_id", wb_inst_id, id);
        check("wb_valid", 64'(wb_valid), 64'(!flush));
        rdata = wb_rdata;
        @(posedge clk);
        #1;
    endtask

    // issue without flush and keep the model memory in step
    task automatic run_op(input mem_op_t op, input xlen_t addr, input xlen_t wdata);
        xlen_t                 got;
        int                    stalls;
        logic [RAM_ADDR_W-1:0] idx;
        idx = addr[RAM_ADDR_W-1:0];
        issue(op, addr, wdata, 1'b0, got, stalls);
        case (op)
            MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW:
                check($sformatf("%s from word %0d", op.name(), idx), 64'(got),
                      64'(load_expect(op, model_mem[idx])));
            MEM_SB, MEM_SH, MEM_SW:
                model_mem[idx] = store_merge(op, model_mem[idx], wdata);
            MEM_AMOSWAP: begin
                check($sformatf("swap old word %0d", idx), 64'(got), 64'(model_mem[idx]));
                model_mem[idx] = wdata;
            end
            default: check("stall cycles on MEM_NONE", 64'(stalls), 64'd0);
        endcase
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        xlen_t got;
        xlen_t addr;
        int    stalls;
        logic  flush;
        void'($urandom(RNG_SEED));
        clk = 1'b0;
        rst_n = 1'b0;
        mem_valid = 1'b0;
        mem_inst_id = '0;
        mem_op = MEM_NONE;
        mem_addr = '0;
        mem_wdata = '0;
        pipeline_flush = 1'b0;
        next_id = 64'd1;
        cycle_count = 0;
        test_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check("mem_stall after reset", 64'(mem_stall), 64'd0);
        check("wb_valid after reset", 64'(wb_valid), 64'd0);
        @(posedge clk);
        #1;
        finish_test("reset");
        // every word gets a known value before any load
        for (int i = 0; i < RAM_WORDS; i++) run_op(MEM_SW, xlen_t'(i), $urandom);
        for (int i = 0; i < 40; i++) begin
            addr = $urandom_range(0, RAM_WORDS - 1);
            run_op(mem_op_t'(4'(int'(MEM_SB) + $urandom_range(0, 2))), addr, $urandom);
            run_op(MEM_LW, addr, '0);
        end
        finish_test("store_load");
        for (int i = 0; i < 40; i++) begin
            addr = $urandom_range(0, RAM_WORDS - 1);
            run_op(mem_op_t'(4'(int'(MEM_LB) + $urandom_range(0, 3))), addr, '0);
        end
        finish_test("load_extend");
        for (int i = 0; i < 20; i++) begin
            addr = $urandom_range(0, RAM_WORDS - 1);
            run_op(MEM_AMOSWAP, addr, $urandom);
            run_op(MEM_LW, addr, '0);
        end
        finish_test("swap");
        for (int i = 0; i < 20; i++) begin
            flush = 1'($urandom_range(0, 1));
            issue(MEM_NONE, $urandom, $urandom, flush, got, stalls);
            check("stall cycles on MEM_NONE", 64'(stalls), 64'd0);
        end
        pipeline_flush = 1'b0;
        finish_test("control");
        for (int i = 0; i < 500; i++) begin
            addr = $urandom_range(0, RAM_WORDS - 1);
            run_op(mem_op_t'(4'($urandom_range(0, 9))), addr, $urandom);
        end
        for (int i = 0; i < 16; i++) run_op(MEM_LW, $urandom_range(0, RAM_WORDS - 1), '0);
        finish_test("random_mix");
        mem_valid = 1'b0;
        repeat (2) @(posedge clk);
        $display("summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: mem_subsys_top.f
src/mem_pkg.sv
src/dmem_if.sv
src/mem_stage.sv
src/data_ram.sv
src/mem_subsys_top.sv
verif/tb_mem_subsys.sv

// File: run_sim.sh
#!/bin/sh
# build and run the memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module tb_mem_subsys \
    -f mem_subsys_top.f \
    -o sim_mem_subsys

./obj_dir/sim_mem_subsys | tee sim.log

if grep -q "Verification failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"
